// ==== src.f ====
logic/vic_video_pkg.sv
logic/video_if.sv
logic/video_config_regs.sv
logic/raster_timing.sv
logic/pixel_select.sv
logic/palette_lookup.sv
logic/vic_video_top.sv
verification/vic_video_assertions.sv
verification/vic_video_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the video pipeline testbench with verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module vic_video_tb \
      -f src.f -o vic_video_sim; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/vic_video_sim
status=$?
if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit "$status"
fi
exit 0

// ==== verification/vic_video_tb.sv ====
`timescale 1ns/1ps

module vic_video_tb import vic_video_pkg::*; ();

   localparam int FRAME_TIMEOUT = 160000;   // longer than one pal frame

   // one output dot as the reference predicts it
   typedef struct packed {
      rgb6_t red;
      rgb6_t green;
      rgb6_t blue;
      logic  hsync;
      logic  vsync;
      logic  active;
   } dot_t;

   logic              sys_clock;
   logic              reset;
   logic              psel, penable, pwrite, paddr;
   logic [7:0]        pwdata;
   logic [7:0]        prdata;
   logic              pready;
   color_index_t      pixel_index;
   logic [X_BITS-1:0] raster_x;
   logic [Y_BITS-1:0] raster_y;
   rgb6_t             red, green, blue;
   logic              hsync, vsync, active;

   integer            seed = 78;
   logic              tracking;               // compare process enabled
   logic [X_BITS-1:0] exp_x;                  // where the raster should be now
   logic [Y_BITS-1:0] exp_y;
   cfg_word_u         shadow_ctrl;            // register contents as written over apb
   cfg_word_u         shadow_color;
   cfg_word_u         word;
   string             test_name;
   dot_t              expect_q[$];            // dots still in the pipeline

   vic_video_top DUT (.*);

   always #5 sys_clock = ~sys_clock;

   // new random pixel every dot
   always @(posedge sys_clock) begin
      #1;
      pixel_index = color_index_t'($random(seed));
   end

   task automatic abort_run();
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_rgb(input string name, input rgb6_t exp, input rgb6_t act);
      if (act !== exp) begin
         $display("mismatch %s expected %0d actual %0d", name, exp, act);
         abort_run();
      end
   endtask

   // bits are {hsync, vsync, active}
   task automatic check_sync(input string name, input logic [2:0] exp, input logic [2:0] act);
      if (act !== exp) begin
         $display("mismatch %s expected %b actual %b", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_reg(input string name, input cfg_word_u exp, input cfg_word_u act);
      if (act !== exp) begin
         $display("mismatch %s expected %h actual %h", name, exp, act);
         abort_run();
      end
   endtask

   task automatic check_pos(input string name,
                            input logic [X_BITS-1:0] ex, input logic [Y_BITS-1:0] ey,
                            input logic [X_BITS-1:0] ax, input logic [Y_BITS-1:0] ay);
      if (ax !== ex || ay !== ey) begin
         $display("mismatch %s expected %0d,%0d actual %0d,%0d", name, ex, ey, ax, ay);
         abort_run();
      end
   endtask

   // expected output for one dot, straight from the video rules
   function automatic dot_t reference_dot(input logic [X_BITS-1:0] x,
                                          input logic [Y_BITS-1:0] y,
                                          input color_index_t pix,
                                          input cfg_word_u ctrl, input cfg_word_u colors);
      dot_t              d;
      logic [Y_BITS-1:0] v_vis;
      logic [Y_BITS-1:0] vs0;
      logic              win;
      color_index_t      idx;
      v_vis    = ctrl.ctrl_view.chip_ntsc ? V_VISIBLE_NTSC : V_VISIBLE_PAL;
      vs0      = ctrl.ctrl_view.chip_ntsc ? VSYNC_START_NTSC : VSYNC_START_PAL;
      d.active = (x < H_VISIBLE) && (y < v_vis);
      d.hsync  = (x >= HSYNC_START) && (x < HSYNC_START + HSYNC_LEN);
      d.vsync  = (y >= vs0) && (y < vs0 + VSYNC_LEN);
      win = (x >= WIN_X0) && (x < WIN_X0 + WIN_W) && (y >= WIN_Y0) && (y < WIN_Y0 + WIN_H);
      if (!win)
         idx = colors.color_view.border;
      else if (pix == 4'd0)
         idx = colors.color_view.background;   // transparent pixel
      else
         idx = pix;
      if (d.active && !(ctrl.ctrl_view.hide_raster && y[0]))
         {d.red, d.green, d.blue} = PALETTE[idx];
      else
         {d.red, d.green, d.blue} = 18'd0;     // blanked
      return d;
   endfunction

   task automatic apb_write(input logic addr, input cfg_word_u data);
      @(posedge sys_clock);
      #1;
      psel   = 1'b1;   // setup phase
      pwrite = 1'b1;
      paddr  = addr;
      pwdata = data;
      @(posedge sys_clock);
      #1;
      penable = 1'b1;
      @(posedge sys_clock);   // write lands on this edge
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      if (addr == REG_CTRL)
         shadow_ctrl = data;
      else
         shadow_color = data;
   endtask

   task automatic apb_read(input logic addr, output cfg_word_u data);
      @(posedge sys_clock);
      #1;
      psel   = 1'b1;
      pwrite = 1'b0;
      paddr  = addr;
      @(posedge sys_clock);
      #1;
      penable = 1'b1;
      @(negedge sys_clock);   // middle of the access phase
      data = prdata;
      @(posedge sys_clock);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic wait_pos(input logic [X_BITS-1:0] x, input logic [Y_BITS-1:0] y,
                           input int limit);
      for (int n = 0; n < limit; n++) begin
         @(negedge sys_clock);
         if (raster_x == x && raster_y == y)
            return;
      end
      $display("timeout: raster did not reach %0d,%0d within %0d cycles", x, y, limit);
      abort_run();
   endtask

   // compare process, outputs lag the sampled dot by two cycles
   always @(negedge sys_clock) begin
      dot_t              due;
      logic [X_BITS-1:0] last_x;
      logic [Y_BITS-1:0] last_y;
      if (tracking) begin
         check_pos({test_name, " raster"}, exp_x, exp_y, raster_x, raster_y);
         expect_q.push_back(reference_dot(exp_x, exp_y, pixel_index, shadow_ctrl,
                                          shadow_color));
         if (expect_q.size() == 3) begin
            due = expect_q.pop_front();
            check_rgb({test_name, " red"}, due.red, red);
            check_rgb({test_name, " green"}, due.green, green);
            check_rgb({test_name, " blue"}, due.blue, blue);
            check_sync({test_name, " sync"}, {due.hsync, due.vsync, due.active},
                       {hsync, vsync, active});
         end
         last_x = shadow_ctrl.ctrl_view.chip_ntsc ? NTSC_LINE_DOTS - 1'b1 : PAL_LINE_DOTS - 1'b1;
         last_y = shadow_ctrl.ctrl_view.chip_ntsc ? NTSC_LINES - 1'b1 : PAL_LINES - 1'b1;
         if (exp_x == last_x) begin
            exp_x = '0;
            exp_y = (exp_y == last_y) ? '0 : exp_y + 1'b1;
         end else begin
            exp_x = exp_x + 1'b1;
         end
      end
   end

   initial begin
      sys_clock    = 1'b0;
      reset        = 1'b1;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      paddr        = 1'b0;
      pwdata       = '0;
      pixel_index  = '0;
      tracking     = 1'b0;
      exp_x        = '0;
      exp_y        = '0;
      shadow_ctrl  = '0;
      shadow_color = '0;
      test_name    = "reset";
      repeat (5) @(posedge sys_clock);
      #1;
      reset    = 1'b0;
      tracking = 1'b1;   // raster holds 0,0 until the next edge
      @(negedge sys_clock);
      check_sync("reset sync", 3'b000, {hsync, vsync, active});
      check_rgb("reset red", '0, red);
      check_rgb("reset green", '0, green);
      check_rgb("reset blue", '0, blue);
      check_pos("reset position", '0, '0, raster_x, raster_y);
      apb_read(REG_CTRL, word);
      check_reg("reset ctrl", '0, word);
      apb_read(REG_COLOR, word);
      check_reg("reset color", '0, word);

      test_name = "register access";
      apb_write(REG_CTRL, 8'h02);    // hide_raster on, still pal
      apb_read(REG_CTRL, word);
      check_reg("ctrl read back", 8'h02, word);
      apb_write(REG_COLOR, 8'h6E);   // background blue, border light blue
      apb_read(REG_COLOR, word);
      check_reg("color read back", 8'h6E, word);
      apb_read(REG_CTRL, word);
      check_reg("ctrl after color write", 8'h02, word);
      apb_write(REG_CTRL, 8'h00);

      test_name = "pal frame";
      wait_pos(PAL_LINE_DOTS - 1'b1, PAL_LINES - 1'b1, FRAME_TIMEOUT);   // end of first frame
      wait_pos(PAL_LINE_DOTS - 1'b1, PAL_LINES - 1'b1, FRAME_TIMEOUT);   // one whole frame

      test_name = "hide raster";
      apb_write(REG_CTRL, 8'h02);
      wait_pos(PAL_LINE_DOTS - 1'b1, PAL_LINES - 1'b1, FRAME_TIMEOUT);

      // model switch, compare paused around the restart
      test_name = "ntsc switch";
      @(posedge sys_clock);
      #1;
      tracking = 1'b0;
      apb_write(REG_CTRL, 8'h01);
      @(negedge sys_clock);   // restart pending
      @(negedge sys_clock);
      check_pos("ntsc restart", '0, '0, raster_x, raster_y);
      @(posedge sys_clock);
      #1;
      exp_x = 10'd1;
      exp_y = '0;
      expect_q.delete();
      tracking  = 1'b1;
      test_name = "ntsc frame";
      wait_pos(NTSC_LINE_DOTS - 1'b1, NTSC_LINES - 1'b1, FRAME_TIMEOUT);
      wait_pos('0, '0, 1);   // frame wraps right after line 262

      $display("No errors");
      $finish;
   end

endmodule

// ==== verification/vic_video_assertions.sv ====
`timescale 1ns/1ps

module vic_video_assertions import vic_video_pkg::*; (
   input logic              sys_clock,
   input logic              reset,
   input logic              pready,
   input rgb6_t             red,
   input rgb6_t             green,
   input rgb6_t             blue,
   input logic              active,
   input logic [X_BITS-1:0] raster_x
);

   // zero wait state slave
   pready_high: assert property (@(posedge sys_clock) disable iff (reset) pready)
      else $error("pready went low");

   // blanking outside the visible area
   rgb_blank: assert property (@(posedge sys_clock) disable iff (reset)
      !active |-> (red == '0 && green == '0 && blue == '0))
      else $error("rgb not zero while active is low");

   x_in_line: assert property (@(posedge sys_clock) disable iff (reset)
      raster_x < NTSC_LINE_DOTS)   // ntsc has the longest line
      else $error("raster_x beyond the line length");

endmodule

bind vic_video_top vic_video_assertions u_assertions (
   .sys_clock (sys_clock),
   .reset     (reset),
   .pready    (pready),
   .red       (red),
   .green     (green),
   .blue      (blue),
   .active    (active),
   .raster_x  (raster_x)
);

// ==== logic/vic_video_top.sv ====
`timescale 1ns/1ps

module vic_video_top import vic_video_pkg::*; (
   input  logic              sys_clock,
   input  logic              reset,
   // apb slave
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic              paddr,
   input  logic [7:0]        pwdata,
   output logic [7:0]        prdata,
   output logic              pready,
   // pixel in, sampled at raster_x/raster_y
   input  color_index_t      pixel_index,
   output logic [X_BITS-1:0] raster_x,
   output logic [Y_BITS-1:0] raster_y,
   // video out, two dots behind the raster
   output rgb6_t             red,
   output rgb6_t             green,
   output rgb6_t             blue,
   output logic              hsync,
   output logic              vsync,
   output logic              active
);

   config_if cfg_bus ();
   raster_if raster_bus ();
   color_if  color_bus ();

   video_config_regs u_regs (
      .sys_clock (sys_clock),
      .reset     (reset),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .pready    (pready),
      .cfg       (cfg_bus.driver)
   );

   raster_timing u_raster (
      .sys_clock (sys_clock),
      .reset     (reset),
      .cfg       (cfg_bus.chip_reader),
      .out       (raster_bus.source)
   );

   pixel_select u_select (
      .sys_clock   (sys_clock),
      .reset       (reset),
      .cfg         (cfg_bus.color_reader),
      .pixel_index (pixel_index),
      .in          (raster_bus.sink),
      .out         (color_bus.source)
   );

   palette_lookup u_palette (
      .sys_clock (sys_clock),
      .reset     (reset),
      .in        (color_bus.sink),
      .red       (red),
      .green     (green),
      .blue      (blue),
      .hsync     (hsync),
      .vsync     (vsync),
      .active    (active)
   );

   assign raster_x = raster_bus.x;   // current dot position
   assign raster_y = raster_bus.y;

endmodule

// ==== logic/palette_lookup.sv ====
`timescale 1ns/1ps

module palette_lookup import vic_video_pkg::*; (
   input  logic     sys_clock,
   input  logic     reset,
   color_if.sink    in,
   output rgb6_t    red,
   output rgb6_t    green,
   output rgb6_t    blue,
   output logic     hsync,
   output logic     vsync,
   output logic     active
);

   logic [17:0] entry;   // {r, g, b} for the incoming index
   logic        show;

   assign entry = PALETTE[in.index];
   assign show  = in.active && !in.hidden;   // blank outside display or hidden line

   always_ff @(posedge sys_clock) begin
      if (reset) begin
         red    <= '0;
         green  <= '0;
         blue   <= '0;
         hsync  <= 1'b0;
         vsync  <= 1'b0;
         active <= 1'b0;
      end else begin
         {red, green, blue} <= show ? entry : 18'd0;
         hsync  <= in.hsync;
         vsync  <= in.vsync;
         active <= in.active;   // stays high on hidden lines
      end
   end

endmodule

// ==== logic/pixel_select.sv ====
`timescale 1ns/1ps

module pixel_select import vic_video_pkg::*; (
   input  logic           sys_clock,
   input  logic           reset,
   config_if.color_reader cfg,
   input  color_index_t   pixel_index,
   raster_if.sink         in,
   color_if.source        out
);

   logic         in_window;
   logic         hidden_next;
   color_index_t index_next;

   // inner 320x200 area, the rest is border
   assign in_window = (in.x >= WIN_X0) && (in.x < WIN_X0 + WIN_W)
                   && (in.y >= WIN_Y0) && (in.y < WIN_Y0 + WIN_H);

   always_comb begin
      if (!in_window)
         index_next = cfg.border_color;
      else if (pixel_index == 4'd0)
         index_next = cfg.background_color;   // index 0 shows background
      else
         index_next = pixel_index;
   end

   assign hidden_next = cfg.hide_raster && in.y[0];   // odd lines only

   always_ff @(posedge sys_clock) begin
      if (reset) begin
         out.hsync  <= 1'b0;
         out.vsync  <= 1'b0;
         out.active <= 1'b0;
         out.hidden <= 1'b0;
      end else begin
         out.hsync  <= in.hsync;
         out.vsync  <= in.vsync;
         out.active <= in.active;
         out.hidden <= hidden_next;
      end
   end

   // colour index travels beside the syncs, masked later by active
   always_ff @(posedge sys_clock) begin
      out.index <= index_next;
   end

endmodule

// ==== logic/raster_timing.sv ====
`timescale 1ns/1ps

module raster_timing import vic_video_pkg::*; (
   input  logic          sys_clock,
   input  logic          reset,
   config_if.chip_reader cfg,
   raster_if.source      out
);

   logic [X_BITS-1:0] x_q, x_next;
   logic [Y_BITS-1:0] y_q, y_next;
   logic [X_BITS-1:0] line_last;    // last dot of a line, current model
   logic [Y_BITS-1:0] frame_last;   // last line of a frame, current model
   logic [Y_BITS-1:0] vs_start;     // for the model of the next dot
   logic [Y_BITS-1:0] v_visible;
   logic              model_q;      // model the counters run with
   logic              restart;
   logic              hsync_q, vsync_q, active_q;
   logic              hsync_next, vsync_next, active_next;

   assign restart    = cfg.chip_ntsc != model_q;   // model switched by a register write
   assign line_last  = model_q ? NTSC_LINE_DOTS - 1'b1 : PAL_LINE_DOTS - 1'b1;
   assign frame_last = model_q ? NTSC_LINES - 1'b1 : PAL_LINES - 1'b1;
   assign vs_start   = cfg.chip_ntsc ? VSYNC_START_NTSC : VSYNC_START_PAL;
   assign v_visible  = cfg.chip_ntsc ? V_VISIBLE_NTSC : V_VISIBLE_PAL;

   always_comb begin
      x_next = x_q + 1'b1;
      y_next = y_q;
      if (restart) begin
         x_next = '0;
         y_next = '0;
      end else if (x_q == line_last) begin
         x_next = '0;
         y_next = (y_q == frame_last) ? '0 : y_q + 1'b1;
      end
   end

   // syncs decoded from the next position so they line up with the counters
   always_comb begin
      hsync_next  = (x_next >= HSYNC_START) && (x_next < HSYNC_START + HSYNC_LEN);
      vsync_next  = (y_next >= vs_start) && (y_next < vs_start + VSYNC_LEN);
      active_next = (x_next < H_VISIBLE) && (y_next < v_visible);
   end

   always_ff @(posedge sys_clock) begin
      if (reset) begin
         x_q      <= '0;
         y_q      <= '0;
         model_q  <= 1'b0;
         hsync_q  <= 1'b0;
         vsync_q  <= 1'b0;
         active_q <= 1'b1;   // dot 0,0 is inside the visible area
      end else begin
         x_q      <= x_next;
         y_q      <= y_next;
         model_q  <= cfg.chip_ntsc;
         hsync_q  <= hsync_next;
         vsync_q  <= vsync_next;
         active_q <= active_next;
      end
   end

   assign out.x      = x_q;
   assign out.y      = y_q;
   assign out.hsync  = hsync_q;
   assign out.vsync  = vsync_q;
   assign out.active = active_q;

endmodule

// ==== logic/video_config_regs.sv ====
`timescale 1ns/1ps

module video_config_regs import vic_video_pkg::*; (
   input  logic      sys_clock,
   input  logic      reset,
   input  logic      psel,
   input  logic      penable,
   input  logic      pwrite,
   input  logic      paddr,
   input  cfg_word_u pwdata,
   output logic [7:0] prdata,
   output logic      pready,
   config_if.driver  cfg
);

   logic         wr_en;
   logic         rd_en;
   logic         chip_ntsc_q;
   logic         hide_raster_q;
   color_index_t border_q;
   color_index_t background_q;
   cfg_word_u    rd_word;

   assign wr_en = psel && penable && pwrite;    // access phase of a write
   assign rd_en = psel && penable && !pwrite;
   assign pready = 1'b1;                        // no wait states

   always_ff @(posedge sys_clock) begin
      if (reset) begin
         chip_ntsc_q   <= 1'b0;   // pal
         hide_raster_q <= 1'b0;
         border_q      <= '0;
         background_q  <= '0;
      end else if (wr_en) begin
         case (paddr)
            REG_CTRL: begin
               chip_ntsc_q   <= pwdata.ctrl_view.chip_ntsc;
               hide_raster_q <= pwdata.ctrl_view.hide_raster;   // reserved bits dropped
            end
            REG_COLOR: begin
               border_q     <= pwdata.color_view.border;
               background_q <= pwdata.color_view.background;
            end
            default: ;   // unmapped, ignore
         endcase
      end
   end

   // read mux, rebuilds the word through the matching view
   always_comb begin
      rd_word = '0;
      case (paddr)
         REG_CTRL: begin
            rd_word.ctrl_view.chip_ntsc   = chip_ntsc_q;
            rd_word.ctrl_view.hide_raster = hide_raster_q;
         end
         REG_COLOR: begin
            rd_word.color_view.border     = border_q;
            rd_word.color_view.background = background_q;
         end
         default: rd_word = '0;
      endcase
   end

   assign prdata = rd_en ? rd_word : 8'h00;   // bus idles at zero

   assign cfg.chip_ntsc        = chip_ntsc_q;
   assign cfg.hide_raster      = hide_raster_q;
   assign cfg.border_color     = border_q;
   assign cfg.background_color = background_q;

endmodule

// ==== logic/video_if.sv ====
`timescale 1ns/1ps

// configuration from the register block to the pipeline
interface config_if import vic_video_pkg::*; ();
   logic         chip_ntsc;
   logic         hide_raster;
   color_index_t border_color;
   color_index_t background_color;

   modport driver (output chip_ntsc, hide_raster, border_color, background_color);
   modport chip_reader (input chip_ntsc);   // raster stage only needs the model
   modport color_reader (input hide_raster, border_color, background_color);
endinterface

// raster position plus syncs, aligned to the same dot
interface raster_if import vic_video_pkg::*; ();
   logic [X_BITS-1:0] x;
   logic [Y_BITS-1:0] y;
   logic              hsync;
   logic              vsync;
   logic              active;

   modport source (output x, y, hsync, vsync, active);
   modport sink (input x, y, hsync, vsync, active);
endinterface

// chosen colour index, one cycle behind the raster
interface color_if import vic_video_pkg::*; ();
   color_index_t index;
   logic         hsync;
   logic         vsync;
   logic         active;
   logic         hidden;   // line is blanked by hide_raster

   modport source (output index, hsync, vsync, active, hidden);
   modport sink (input index, hsync, vsync, active, hidden);
endinterface

// ==== logic/vic_video_pkg.sv ====
package vic_video_pkg;

   // counter widths, sized to hold the longest line and the tallest frame
   localparam int X_BITS = 10;
   localparam int Y_BITS = 9;

   typedef logic [3:0] color_index_t;   // one of the 16 vic-ii colours
   typedef logic [5:0] rgb6_t;          // one dac channel

   // frame geometry per chip model
   localparam logic [X_BITS-1:0] PAL_LINE_DOTS  = 10'd504;
   localparam logic [Y_BITS-1:0] PAL_LINES      = 9'd312;
   localparam logic [X_BITS-1:0] NTSC_LINE_DOTS = 10'd520;
   localparam logic [Y_BITS-1:0] NTSC_LINES     = 9'd263;

   // visible area starts at 0,0
   localparam logic [X_BITS-1:0] H_VISIBLE      = 10'd403;
   localparam logic [Y_BITS-1:0] V_VISIBLE_PAL  = 9'd284;
   localparam logic [Y_BITS-1:0] V_VISIBLE_NTSC = 9'd235;

   localparam logic [X_BITS-1:0] HSYNC_START      = 10'd440;
   localparam logic [X_BITS-1:0] HSYNC_LEN        = 10'd40;
   localparam logic [Y_BITS-1:0] VSYNC_START_PAL  = 9'd300;
   localparam logic [Y_BITS-1:0] VSYNC_START_NTSC = 9'd250;
   localparam logic [Y_BITS-1:0] VSYNC_LEN        = 9'd3;

   // 320x200 display window, everything else inside the visible area is border
   localparam logic [X_BITS-1:0] WIN_X0 = 10'd42;
   localparam logic [Y_BITS-1:0] WIN_Y0 = 9'd51;
   localparam logic [X_BITS-1:0] WIN_W  = 10'd320;
   localparam logic [Y_BITS-1:0] WIN_H  = 9'd200;

   // entry is {red, green, blue}, 6 bits each
   localparam logic [0:15][17:0] PALETTE = {
      {6'd0,  6'd0,  6'd0 },   // black
      {6'd63, 6'd63, 6'd63},   // white
      {6'd26, 6'd13, 6'd10},   // red
      {6'd28, 6'd41, 6'd44},   // cyan
      {6'd27, 6'd15, 6'd33},   // purple
      {6'd22, 6'd35, 6'd16},   // green
      {6'd13, 6'd10, 6'd30},   // blue
      {6'd46, 6'd49, 6'd27},   // yellow
      {6'd27, 6'd19, 6'd9 },   // orange
      {6'd16, 6'd14, 6'd0 },   // brown
      {6'd38, 6'd25, 6'd22},   // light red
      {6'd17, 6'd17, 6'd17},   // dark grey
      {6'd27, 6'd27, 6'd27},   // grey
      {6'd38, 6'd52, 6'd33},   // light green
      {6'd27, 6'd23, 6'd45},   // light blue
      {6'd37, 6'd37, 6'd37}    // light grey
   };

   // one apb data byte, meaning depends on the register addressed
   typedef union packed {
      struct packed {
         logic [5:0] reserved;
         logic       hide_raster;   // blank odd lines
         logic       chip_ntsc;     // 0 pal, 1 ntsc
      } ctrl_view;
      struct packed {
         color_index_t background;
         color_index_t border;
      } color_view;
   } cfg_word_u;

   localparam logic REG_CTRL  = 1'b0;
   localparam logic REG_COLOR = 1'b1;

endpackage
